// ==== bus_frontend/i3c_bus_monitor.sv ====
// Module i3c_bus_monitor: SCL/SDA synchroniser with START, Sr and STOP detection
`timescale 1ns/1ps
`default_nettype none

module i3c_bus_monitor (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  scl_i,
  input  logic                  sda_i,
  output i3c_rx_pkg::bus_evt_t  evt_o
);

  logic [1:0] scl_sync_q;
  logic [1:0] sda_sync_q;
  logic       scl_prev_q;
  logic       sda_prev_q;
  logic       busy_q;
  logic       scl_s;
  logic       sda_s;
  logic       scl_high;
  logic       start_cond;
  logic       stop_cond;
  i3c_rx_pkg::bus_evt_t evt_q;

  assign scl_s = scl_sync_q[1];
  assign sda_s = sda_sync_q[1];

  // SCL must be high on both samples around the SDA edge
  assign scl_high   = scl_s & scl_prev_q;
  assign start_cond = scl_high & sda_prev_q & ~sda_s;
  assign stop_cond  = scl_high & ~sda_prev_q & sda_s;

  // Idle bus is pulled high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= 2'b11;
      sda_sync_q <= 2'b11;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[0], scl_i};
      sda_sync_q <= {sda_sync_q[0], sda_i};
      scl_prev_q <= scl_s;
      sda_prev_q <= sda_s;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      evt_q  <= '0;
    end else begin
      if (start_cond) begin
        busy_q <= 1'b1;
      end else if (stop_cond) begin
        busy_q <= 1'b0;
      end
      evt_q.start    <= start_cond & ~busy_q;
      evt_q.rstart   <= start_cond & busy_q;
      evt_q.stop     <= stop_cond;
      evt_q.scl_rise <= scl_s & ~scl_prev_q;
      evt_q.scl_fall <= ~scl_s & scl_prev_q;
      evt_q.sda      <= sda_s;
    end
  end

  assign evt_o = evt_q;

endmodule

`default_nettype wire

// ==== bus_frontend/i3c_byte_receiver.sv ====
// Module i3c_byte_receiver: address match, ACK drive, T-bit check and byte push
`timescale 1ns/1ps
`default_nettype none

`include "i3c_rx_consts.svh"

module i3c_byte_receiver (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  i3c_rx_pkg::bus_evt_t     evt_i,
  input  logic [`I3C_ADDR_W-1:0]   sta_addr_i,
  input  logic                     sta_addr_valid_i,
  input  logic [`I3C_ADDR_W-1:0]   dyn_addr_i,
  input  logic                     dyn_addr_valid_i,
  input  logic                     fifo_full_i,
  output logic                     fifo_push_o,
  output i3c_rx_pkg::rx_byte_t     fifo_data_o,
  output logic                     sda_o,
  output logic [`I3C_DATA_W-1:0]   addr_o,
  output logic                     addr_valid_o,
  output logic                     parity_err_o,
  output logic                     overflow_o
);

  typedef enum logic [2:0] {
    st_idle,
    st_addr,
    st_ack,
    st_data,
    st_parity
  } state_e;

  state_e                   state_q;
  logic [2:0]               bit_cnt_q;
  logic [`I3C_DATA_W-1:0]   shift_q;
  logic [`I3C_DATA_W-1:0]   addr_q;
  logic [`I3C_DATA_W-1:0]   byte_in;
  logic                     addr_valid_q;
  logic                     addr_match;
  logic                     sda_low_q;
  logic                     t_ok;
  logic                     perr_q;
  logic                     byte_done;
  logic                     end_of_xfer;
  logic                     push_req;
  logic                     hold_valid_q;
  logic                     push_q;
  logic                     ovf_q;
  i3c_rx_pkg::rx_byte_t     hold_q;
  i3c_rx_pkg::rx_byte_t     push_data_q;

  assign byte_in = {shift_q[`I3C_DATA_W-2:0], evt_i.sda};

  // Private writes only, RnW is the LSB of the address byte
  assign addr_match = ~byte_in[0] &
                      ((sta_addr_valid_i & (byte_in[`I3C_DATA_W-1:1] == sta_addr_i)) |
                       (dyn_addr_valid_i & (byte_in[`I3C_DATA_W-1:1] == dyn_addr_i)));

  // Data plus T-bit must hold an odd number of ones
  assign t_ok = ^{shift_q, evt_i.sda};

  assign byte_done   = (state_q == st_parity) & evt_i.scl_rise;
  assign end_of_xfer = evt_i.stop | evt_i.rstart;
  assign push_req    = hold_valid_q & (byte_done | end_of_xfer);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= st_idle;
      bit_cnt_q    <= '0;
      sda_low_q    <= 1'b0;
      hold_valid_q <= 1'b0;
      addr_valid_q <= 1'b0;
      perr_q       <= 1'b0;
      push_q       <= 1'b0;
      ovf_q        <= 1'b0;
    end else begin
      addr_valid_q <= 1'b0;
      perr_q       <= 1'b0;
      push_q       <= push_req & ~fifo_full_i;
      ovf_q        <= push_req & fifo_full_i;
      if (evt_i.start | evt_i.rstart) begin
        state_q      <= st_addr;
        bit_cnt_q    <= '0;
        sda_low_q    <= 1'b0;
        hold_valid_q <= 1'b0;
      end else if (evt_i.stop) begin
        state_q      <= st_idle;
        sda_low_q    <= 1'b0;
        hold_valid_q <= 1'b0;
      end else begin
        unique case (state_q)
          st_addr: begin
            if (evt_i.scl_rise) begin
              bit_cnt_q <= bit_cnt_q + 3'd1;
              if (bit_cnt_q == 3'd7) begin
                addr_valid_q <= 1'b1;
                bit_cnt_q    <= '0;
                state_q      <= addr_match ? st_ack : st_idle;
              end
            end
          end
          // bit_cnt_q marks whether SDA is already pulled for the ACK
          st_ack: begin
            if (evt_i.scl_fall) begin
              if (bit_cnt_q == 3'd0) begin
                sda_low_q <= 1'b1;
                bit_cnt_q <= 3'd1;
              end else begin
                sda_low_q <= 1'b0;
                bit_cnt_q <= '0;
                state_q   <= st_data;
              end
            end
          end
          st_data: begin
            if (evt_i.scl_rise) begin
              bit_cnt_q <= bit_cnt_q + 3'd1;
              if (bit_cnt_q == 3'd7) begin
                state_q <= st_parity;
              end
            end
          end
          st_parity: begin
            if (evt_i.scl_rise) begin
              perr_q       <= ~t_ok;
              hold_valid_q <= 1'b1;
              bit_cnt_q    <= '0;
              state_q      <= st_data;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (evt_i.scl_rise && (state_q == st_addr || state_q == st_data)) begin
      shift_q <= byte_in;
    end
    if (evt_i.scl_rise && state_q == st_addr && bit_cnt_q == 3'd7) begin
      addr_q <= byte_in;
    end
    if (byte_done) begin
      hold_q.data       <= shift_q;
      hold_q.last       <= 1'b0;
      hold_q.parity_err <= ~t_ok;
    end
    // Held byte goes out when the next one completes or the transfer ends
    if (push_req) begin
      push_data_q      <= hold_q;
      push_data_q.last <= end_of_xfer;
    end
  end

  assign sda_o        = ~sda_low_q;
  assign addr_o       = addr_q;
  assign addr_valid_o = addr_valid_q;
  assign parity_err_o = perr_q;
  assign fifo_push_o  = push_q;
  assign fifo_data_o  = push_data_q;
  assign overflow_o   = ovf_q;

endmodule

`default_nettype wire

// ==== common/i3c_rx_consts.svh ====
// Widths, FIFO depth and descriptor field positions of the I3C receive path
`ifndef I3C_RX_CONSTS_SVH
`define I3C_RX_CONSTS_SVH

// Bus byte and target address
`define I3C_DATA_W 8
`define I3C_ADDR_W 7

// Entries in the byte FIFO between receiver and descriptor builder
`define RX_FIFO_DEPTH 8

// RX descriptor word
`define RX_DESC_W 32
`define RX_DESC_LEN_W 16

// Flag positions above the length field
`define RX_DESC_PERR_BIT 16
`define RX_DESC_OVF_BIT 17

// Zero bits above the overflow flag
`define RX_DESC_RSVD_W (`RX_DESC_W - `RX_DESC_OVF_BIT - 1)

`endif

// ==== common/i3c_rx_pkg.sv ====
// Package i3c_rx_pkg with bus event, received byte and RX descriptor types
`default_nettype none

`include "i3c_rx_consts.svh"

package i3c_rx_pkg;

  // One cycle of bus conditions from the monitor
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    logic sda;
  } bus_evt_t;

  typedef struct packed {
    logic [`I3C_DATA_W-1:0] data;
    logic                   last;
    logic                   parity_err;
  } rx_byte_t;

  // Bits 31:18 zero, then overflow, parity_err and len
  typedef struct packed {
    logic [`RX_DESC_RSVD_W-1:0] rsvd;
    logic                       overflow;
    logic                       parity_err;
    logic [`RX_DESC_LEN_W-1:0]  len;
  } rx_desc_t;

endpackage

`default_nettype wire

// ==== hdl/i3c_rx_target.sv ====
// Module i3c_rx_target: I3C target receive path top level
`timescale 1ns/1ps
`default_nettype none

`include "i3c_rx_consts.svh"

module i3c_rx_target (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    ctrl_scl_i,
  input  logic                    ctrl_sda_i,
  output logic                    ctrl_sda_o,
  input  logic [`I3C_ADDR_W-1:0]  target_sta_addr_i,
  input  logic                    target_sta_addr_valid_i,
  input  logic [`I3C_ADDR_W-1:0]  target_dyn_addr_i,
  input  logic                    target_dyn_addr_valid_i,
  output logic                    bus_start_o,
  output logic                    bus_rstart_o,
  output logic                    bus_stop_o,
  output logic [`I3C_DATA_W-1:0]  bus_addr_o,
  output logic                    bus_addr_valid_o,
  input  logic                    rx_queue_full_i,
  output logic                    rx_queue_wvalid_o,
  output logic [`I3C_DATA_W-1:0]  rx_queue_wdata_o,
  output logic                    rx_desc_queue_wvalid_o,
  output logic [`RX_DESC_W-1:0]   rx_desc_queue_wdata_o,
  output logic                    parity_err_o,
  output logic                    rx_overflow_o
);

  i3c_rx_pkg::bus_evt_t evt;
  i3c_rx_pkg::rx_byte_t push_data;
  i3c_rx_pkg::rx_byte_t pop_data;
  i3c_rx_pkg::rx_desc_t desc_wdata;
  i3c_rx_pkg::rx_desc_t desc_out;
  logic                 fifo_push;
  logic                 fifo_full;
  logic                 fifo_empty;
  logic                 fifo_pop;

  i3c_bus_monitor u_bus_monitor (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .scl_i  (ctrl_scl_i),
    .sda_i  (ctrl_sda_i),
    .evt_o  (evt)
  );

  i3c_byte_receiver u_byte_receiver (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .evt_i            (evt),
    .sta_addr_i       (target_sta_addr_i),
    .sta_addr_valid_i (target_sta_addr_valid_i),
    .dyn_addr_i       (target_dyn_addr_i),
    .dyn_addr_valid_i (target_dyn_addr_valid_i),
    .fifo_full_i      (fifo_full),
    .fifo_push_o      (fifo_push),
    .fifo_data_o      (push_data),
    .sda_o            (ctrl_sda_o),
    .addr_o           (bus_addr_o),
    .addr_valid_o     (bus_addr_valid_o),
    .parity_err_o     (parity_err_o),
    .overflow_o       (rx_overflow_o)
  );

  rx_fifo #(
    .item_t (i3c_rx_pkg::rx_byte_t)
  ) u_rx_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (fifo_push),
    .data_i  (push_data),
    .full_o  (fifo_full),
    .empty_o (fifo_empty),
    .pop_i   (fifo_pop),
    .data_o  (pop_data)
  );

  rx_descriptor u_rx_descriptor (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .fifo_empty_i      (fifo_empty),
    .fifo_data_i       (pop_data),
    .fifo_pop_o        (fifo_pop),
    .rx_queue_full_i   (rx_queue_full_i),
    .rx_queue_wvalid_o (rx_queue_wvalid_o),
    .rx_queue_wdata_o  (rx_queue_wdata_o),
    .desc_wvalid_o     (rx_desc_queue_wvalid_o),
    .desc_wdata_o      (desc_wdata)
  );

  // Overflow is signalled by rx_overflow_o only, never in the descriptor
  always_comb begin
    desc_out          = desc_wdata;
    desc_out.overflow = 1'b0;
  end

  assign rx_desc_queue_wdata_o = desc_out;

  assign bus_start_o  = evt.start;
  assign bus_rstart_o = evt.rstart;
  assign bus_stop_o   = evt.stop;

endmodule

`default_nettype wire

// ==== hdl/rx_descriptor.sv ====
// Module rx_descriptor: drains the byte FIFO into the RX data and descriptor queues
`timescale 1ns/1ps
`default_nettype none

`include "i3c_rx_consts.svh"

module rx_descriptor (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    fifo_empty_i,
  input  i3c_rx_pkg::rx_byte_t    fifo_data_i,
  output logic                    fifo_pop_o,
  input  logic                    rx_queue_full_i,
  output logic                    rx_queue_wvalid_o,
  output logic [`I3C_DATA_W-1:0]  rx_queue_wdata_o,
  output logic                    desc_wvalid_o,
  output i3c_rx_pkg::rx_desc_t    desc_wdata_o
);

  logic                       pop;
  logic                       pop_last;
  logic [`RX_DESC_LEN_W-1:0]  count_q;
  logic                       perr_acc_q;
  logic                       desc_arm_q;
  i3c_rx_pkg::rx_desc_t       desc_next;
  i3c_rx_pkg::rx_desc_t       desc_q;

  // One entry per cycle while the data queue has room
  assign pop        = ~fifo_empty_i & ~rx_queue_full_i;
  assign pop_last   = pop & fifo_data_i.last;
  assign fifo_pop_o = pop;

  always_comb begin
    desc_next            = '0;
    desc_next.len        = count_q + 1'b1;
    desc_next.parity_err = perr_acc_q | fifo_data_i.parity_err;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q           <= '0;
      perr_acc_q        <= 1'b0;
      rx_queue_wvalid_o <= 1'b0;
      desc_arm_q        <= 1'b0;
      desc_wvalid_o     <= 1'b0;
    end else begin
      rx_queue_wvalid_o <= pop;
      desc_arm_q        <= pop_last;
      // Descriptor follows the data write of the last byte by one cycle
      desc_wvalid_o     <= desc_arm_q;
      if (pop_last) begin
        count_q    <= '0;
        perr_acc_q <= 1'b0;
      end else if (pop) begin
        count_q    <= count_q + 1'b1;
        perr_acc_q <= perr_acc_q | fifo_data_i.parity_err;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      rx_queue_wdata_o <= fifo_data_i.data;
    end
    if (pop_last) begin
      desc_q <= desc_next;
    end
    if (desc_arm_q) begin
      desc_wdata_o <= desc_q;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rx_fifo.sv ====
// Module rx_fifo: circular buffer with a type parameter, writes dropped when full
`timescale 1ns/1ps
`default_nettype none

`include "i3c_rx_consts.svh"

module rx_fifo #(
  parameter type         item_t = logic [`I3C_DATA_W-1:0],
  parameter int unsigned depth  = `RX_FIFO_DEPTH
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  item_t data_i,
  output logic  full_o,
  output logic  empty_o,
  input  logic  pop_i,
  output item_t data_o
);

  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  item_t            mem_q [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == cnt_w'(depth));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      unique case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the I3C receive path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module tb_i3c_rx_target --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "^ALL CHECKS PASSED$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// ==== sim/i3c_bus_tasks.svh ====
// Bus driver tasks for START, Sr, STOP, data bits, T-bits and ACK sampling
`ifndef I3C_BUS_TASKS_SVH
`define I3C_BUS_TASKS_SVH

// Lands 1 ns after a rising clock edge
task automatic wait_cycles(input int n);
  repeat (n) @(posedge clk_i);
  #1;
endtask

task automatic drive_start();
  // Sr from a low SCL releases SDA and raises SCL first
  if (!scl_drv) begin
    sda_drv = 1'b1;
    wait_cycles(scl_half);
    scl_drv = 1'b1;
    wait_cycles(scl_half);
  end
  sda_drv = 1'b0;
  wait_cycles(scl_half);
  scl_drv = 1'b0;
endtask

task automatic drive_stop();
  sda_drv = 1'b0;
  wait_cycles(scl_half);
  scl_drv = 1'b1;
  wait_cycles(scl_half);
  sda_drv = 1'b1;
  wait_cycles(scl_half);
endtask

task automatic send_bit(input logic b);
  sda_drv = b;
  wait_cycles(scl_half);
  scl_drv = 1'b1;
  wait_cycles(scl_half);
  scl_drv = 1'b0;
endtask

// SDA released, bus level taken at the SCL rise
task automatic read_bit(output logic b);
  sda_drv = 1'b1;
  wait_cycles(scl_half);
  scl_drv = 1'b1;
  b = bus_sda;
  wait_cycles(scl_half);
  scl_drv = 1'b0;
endtask

task automatic send_address_byte(input logic [7:0] addr_byte);
  for (int i = 7; i >= 0; i--) begin
    send_bit(addr_byte[i]);
  end
endtask

task automatic send_frame(input logic [7:0] data, input logic t);
  for (int i = 7; i >= 0; i--) begin
    send_bit(data[i]);
  end
  send_bit(t);
endtask

`endif

// ==== sim/tb_i3c_rx_target.sv ====
// Testbench tb_i3c_rx_target with bus model, scoreboard, assertions and timeout
`timescale 1ns/1ps
`default_nettype none

`include "i3c_rx_consts.svh"

module tb_i3c_rx_target;

  localparam int scl_half    = 8;
  localparam int cycle_limit = 20000;
  localparam logic [`I3C_ADDR_W-1:0] sta_addr = 7'h2a;
  localparam logic [`I3C_ADDR_W-1:0] dyn_addr = 7'h51;

  logic clk_i;
  logic rst_ni;
  logic scl_drv;
  logic sda_drv;
  logic bus_sda;
  logic sda_pull;
  logic sta_addr_valid;
  logic dyn_addr_valid;
  logic rx_queue_full;
  logic bus_start;
  logic bus_rstart;
  logic bus_stop;
  logic [`I3C_DATA_W-1:0] bus_addr;
  logic bus_addr_valid;
  logic rx_wvalid;
  logic [`I3C_DATA_W-1:0] rx_wdata;
  logic desc_wvalid;
  logic [`RX_DESC_W-1:0] desc_wdata;
  logic parity_err;
  logic rx_overflow;

  integer seed;
  int cycle_cnt = 0;
  int start_cnt = 0;
  int rstart_cnt = 0;
  int stop_cnt = 0;
  int perr_cnt = 0;
  int ovf_cnt = 0;
  int wr_cnt = 0;
  int desc_cnt = 0;
  int exp_perr = 0;
  int mark_wr;
  int mark_desc;
  logic [7:0] exp_bytes [$];
  logic [7:0] exp_addrs [$];
  logic [7:0] exp_byte;
  logic [7:0] exp_addr;
  i3c_rx_pkg::rx_desc_t exp_descs [$];
  i3c_rx_pkg::rx_desc_t exp_desc;
  i3c_rx_pkg::rx_desc_t got_desc;

  // Open-drain bus where either side can pull SDA low
  assign bus_sda = sda_drv & sda_pull;

  i3c_rx_target i_i3c_rx_target (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .ctrl_scl_i              (scl_drv),
    .ctrl_sda_i              (bus_sda),
    .ctrl_sda_o              (sda_pull),
    .target_sta_addr_i       (sta_addr),
    .target_sta_addr_valid_i (sta_addr_valid),
    .target_dyn_addr_i       (dyn_addr),
    .target_dyn_addr_valid_i (dyn_addr_valid),
    .bus_start_o             (bus_start),
    .bus_rstart_o            (bus_rstart),
    .bus_stop_o              (bus_stop),
    .bus_addr_o              (bus_addr),
    .bus_addr_valid_o        (bus_addr_valid),
    .rx_queue_full_i         (rx_queue_full),
    .rx_queue_wvalid_o       (rx_wvalid),
    .rx_queue_wdata_o        (rx_wdata),
    .rx_desc_queue_wvalid_o  (desc_wvalid),
    .rx_desc_queue_wdata_o   (desc_wdata),
    .parity_err_o            (parity_err),
    .rx_overflow_o           (rx_overflow)
  );

  always #5 clk_i = ~clk_i;

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("CHECKS FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  `include "i3c_bus_tasks.svh"

  // T-bit that gives data plus T an odd number of ones
  function automatic logic odd_parity_t(input logic [7:0] data);
    return ~(^data);
  endfunction

  // Acked private write of n random bytes; only the first keep bytes reach the queue
  task automatic write_payload(input logic [6:0] addr, input int n, input int bad_idx,
                               input int keep);
    logic sda_seen;
    logic [7:0] data;
    logic t;
    i3c_rx_pkg::rx_desc_t desc;
    exp_addrs.push_back({addr, 1'b0});
    send_address_byte({addr, 1'b0});
    read_bit(sda_seen);
    assert (sda_seen == 1'b0)
      else stop_with_failure($sformatf("ERROR at %0t: address 0x%02h not ACKed", $time, addr));
    for (int i = 0; i < n; i++) begin
      data = 8'($random(seed));
      t = odd_parity_t(data);
      if (i == bad_idx) begin
        t = ~t;
        exp_perr++;
      end
      if (i < keep) begin
        exp_bytes.push_back(data);
      end
      send_frame(data, t);
    end
    if (keep == n) begin
      desc = '0;
      desc.len = `RX_DESC_LEN_W'(n);
      desc.parity_err = (bad_idx >= 0);
      exp_descs.push_back(desc);
    end
  endtask

  // Address that must see a NACK, followed by a byte the target ignores
  task automatic send_unacked(input logic [6:0] addr, input logic rnw);
    logic sda_seen;
    exp_addrs.push_back({addr, rnw});
    send_address_byte({addr, rnw});
    read_bit(sda_seen);
    assert (sda_seen == 1'b1)
      else stop_with_failure($sformatf("ERROR at %0t: address 0x%02h rnw %0b was ACKed",
                                       $time, addr, rnw));
    send_frame(8'hc3, 1'b1);
  endtask

  task automatic wait_drained(input int max_cycles);
    int waited;
    waited = 0;
    while ((exp_bytes.size() != 0 || exp_descs.size() != 0) && waited < max_cycles) begin
      wait_cycles(1);
      waited++;
    end
    assert (waited < max_cycles)
      else stop_with_failure("Expected queue writes did not arrive in time");
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      stop_with_failure($sformatf("Run timed out after %0d cycles", cycle_cnt));
    end
  end

  // Registered outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      start_cnt  += int'(bus_start);
      rstart_cnt += int'(bus_rstart);
      stop_cnt   += int'(bus_stop);
      perr_cnt   += int'(parity_err);
      ovf_cnt    += int'(rx_overflow);
      if (bus_addr_valid) begin
        assert (exp_addrs.size() > 0)
          else stop_with_failure($sformatf("ERROR at %0t: unexpected address 0x%02h",
                                           $time, bus_addr));
        exp_addr = exp_addrs.pop_front();
        assert (bus_addr == exp_addr)
          else stop_with_failure($sformatf("ERROR at %0t: address 0x%02h, expected 0x%02h",
                                           $time, bus_addr, exp_addr));
      end
      if (rx_wvalid) begin
        wr_cnt++;
        assert (exp_bytes.size() > 0)
          else stop_with_failure($sformatf("ERROR at %0t: unexpected data write 0x%02h",
                                           $time, rx_wdata));
        exp_byte = exp_bytes.pop_front();
        assert (rx_wdata == exp_byte)
          else stop_with_failure($sformatf("ERROR at %0t: data 0x%02h, expected 0x%02h",
                                           $time, rx_wdata, exp_byte));
      end
      if (desc_wvalid) begin
        desc_cnt++;
        got_desc = desc_wdata;
        assert (exp_descs.size() > 0)
          else stop_with_failure($sformatf("ERROR at %0t: unexpected descriptor 0x%08h",
                                           $time, desc_wdata));
        exp_desc = exp_descs.pop_front();
        assert (got_desc == exp_desc)
          else stop_with_failure($sformatf(
            "ERROR at %0t: descriptor len %0d perr %0b ovf %0b, expected len %0d perr %0b",
            $time, got_desc.len, got_desc.parity_err, got_desc.overflow,
            exp_desc.len, exp_desc.parity_err));
      end
    end
  end

  a_desc_after_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
      desc_wvalid |-> $past(rx_wvalid))
    else stop_with_failure($sformatf("ERROR at %0t: descriptor without data write", $time));

  initial begin
    seed = 32'h4cf5b1b1;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    scl_drv = 1'b1;
    sda_drv = 1'b1;
    sta_addr_valid = 1'b1;
    dyn_addr_valid = 1'b1;
    rx_queue_full = 1'b0;
    wait_cycles(2);
    rst_ni = 1'b1;
    assert (sda_pull && !bus_start && !bus_rstart && !bus_stop && !bus_addr_valid &&
            !rx_wvalid && !desc_wvalid && !parity_err && !rx_overflow)
      else stop_with_failure($sformatf("ERROR at %0t: outputs not idle after reset", $time));
    wait_cycles(4);

    // Dynamic address, then Sr to the static address
    drive_start();
    write_payload(dyn_addr, 4, -1, 4);
    drive_start();
    write_payload(sta_addr, 3, -1, 3);
    drive_stop();
    wait_drained(200);
    assert (start_cnt == 1 && rstart_cnt == 1 && stop_cnt == 1)
      else stop_with_failure($sformatf("ERROR at %0t: start %0d rstart %0d stop %0d",
                                       $time, start_cnt, rstart_cnt, stop_cnt));

    mark_wr = wr_cnt;
    mark_desc = desc_cnt;
    drive_start();
    send_unacked(7'h33, 1'b0);
    drive_stop();
    drive_start();
    send_unacked(sta_addr, 1'b1);
    drive_stop();
    dyn_addr_valid = 1'b0;
    drive_start();
    send_unacked(dyn_addr, 1'b0);
    drive_stop();
    dyn_addr_valid = 1'b1;
    wait_cycles(20);
    assert (wr_cnt == mark_wr && desc_cnt == mark_desc && stop_cnt == 4)
      else stop_with_failure($sformatf("ERROR at %0t: queue writes after a NACK", $time));

    drive_start();
    write_payload(dyn_addr, 6, -1, 6);
    drive_stop();
    wait_drained(200);

    // Wrong T-bit on the second byte
    drive_start();
    write_payload(sta_addr, 3, 1, 3);
    drive_stop();
    wait_drained(200);
    assert (perr_cnt == exp_perr)
      else stop_with_failure($sformatf("ERROR at %0t: %0d parity pulses, expected %0d",
                                       $time, perr_cnt, exp_perr));

    // Data queue held full until the FIFO overflows
    mark_wr = wr_cnt;
    rx_queue_full = 1'b1;
    drive_start();
    write_payload(dyn_addr, 12, -1, `RX_FIFO_DEPTH);
    drive_stop();
    wait_cycles(10);
    assert (ovf_cnt == 12 - `RX_FIFO_DEPTH && wr_cnt == mark_wr)
      else stop_with_failure($sformatf("ERROR at %0t: %0d overflow pulses, expected %0d",
                                       $time, ovf_cnt, 12 - `RX_FIFO_DEPTH));
    rx_queue_full = 1'b0;
    wait_drained(100);
    wait_cycles(20);

    // Seven transfers in total, one of them continued by a repeated START
    assert (start_cnt == 7 && rstart_cnt == 1 && stop_cnt == 7)
      else stop_with_failure($sformatf("ERROR at %0t: start %0d rstart %0d stop %0d",
                                       $time, start_cnt, rstart_cnt, stop_cnt));

    if (exp_bytes.size() != 0 || exp_descs.size() != 0 || exp_addrs.size() != 0 ||
        perr_cnt != exp_perr) begin
      stop_with_failure("Expected writes or events are still outstanding at the end");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+common
+incdir+sim
common/i3c_rx_pkg.sv
bus_frontend/i3c_bus_monitor.sv
bus_frontend/i3c_byte_receiver.sv
hdl/rx_fifo.sv
hdl/rx_descriptor.sv
hdl/i3c_rx_target.sv
sim/tb_i3c_rx_target.sv
